// ==== include/clk_synth_defaults.svh ====
`ifndef CLK_SYNTH_DEFAULTS_SVH
`define CLK_SYNTH_DEFAULTS_SVH

// ************************************************************
// default words in send order
// low five bits carry the synthesizer register number
// ************************************************************
localparam logic [31:0] SLOT_DEFAULTS [0:25] = '{
    32'h0002_0000,  // slot 0  r0 with reset bit set
    32'h0000_0140,  // slot 1  r0
    32'h0000_0141,  // slot 2  r1
    32'h0000_0142,  // slot 3  r2
    32'h0000_0143,  // slot 4  r3
    32'h4000_0144,  // slot 5  r4
    32'h0000_0145,  // slot 6  r5
    32'h1111_0006,  // slot 7  r6
    32'h1111_0007,  // slot 8  r7
    32'h0101_0008,  // slot 9  r8
    32'h5555_5549,  // slot 10 r9
    32'h9102_410A,  // slot 11 r10
    32'h3400_500B,  // slot 12 r11
    32'h130C_006C,  // slot 13 r12
    32'h3B02_802D,  // slot 14 r13
    32'h1300_000E,  // slot 15 r14
    32'h8000_800F,  // slot 16 r15
    32'hC155_0410,  // slot 17 r16
    32'h0000_0058,  // slot 18 r24
    32'h0200_C319,  // slot 19 r25
    32'h8FA8_001A,  // slot 20 r26
    32'h0000_003B,  // slot 21 r27
    32'h0030_003C,  // slot 22 r28
    32'h0180_033D,  // slot 23 r29
    32'h0200_033E,  // slot 24 r30
    32'h0000_001F   // slot 25 r31
};

`endif

// ==== hdl/clk_synth_reg_pkg.sv ====
package clk_synth_reg_pkg;

    // ************************************************************
    // word and slot types
    // ************************************************************
    localparam int WORD_BITS = 32;              // one synthesizer frame
    typedef logic [WORD_BITS-1:0] cfg_word_t;

    localparam int NUM_SLOTS = 26;              // data slots 0 to 25
    typedef logic [4:0] slot_idx_t;             // slot number and write address

    // control register sits right above the slots
    localparam slot_idx_t CTRL_ADDR    = 5'd26;
    localparam cfg_word_t CTRL_DEFAULT = 32'h0000_0001;  // bit 0 starts a pass

    // per-slot default words
`include "clk_synth_defaults.svh"

    // default word for one slot
    // out-of-range numbers give zero
    function automatic cfg_word_t slot_default(input slot_idx_t idx);
        if (idx < slot_idx_t'(NUM_SLOTS))
        begin
            return SLOT_DEFAULTS[idx];
        end
        return '0;
    endfunction

endpackage

// ==== hdl/clk_synth_timing_pkg.sv ====
package clk_synth_timing_pkg;

    // ************************************************************
    // sequence durations in slow_clk cycles
    // ************************************************************

    // power-up settle time of the synthesizer
    localparam int STARTUP_WAIT_CYCLES = 32768;

    localparam int DEFAULT_LOAD_CYCLES = 32;    // reload hold time
    localparam int SYNC_LOW_CYCLES     = 16;    // sync pulse width

    // counter types
    typedef logic [15:0] startup_cnt_t;         // covers the startup wait
    typedef logic [5:0]  bit_cnt_t;             // frame bits and sync cycles

endpackage

// ==== hdl/cfg_reg_bank.sv ====
module cfg_reg_bank
    import clk_synth_reg_pkg::*;
(
    input  logic      slow_clk,
    input  logic      resetS,
    input  logic      io_sel,             // module selected by host
    input  logic      io_sync,            // host cycle strobe
    input  logic      io_wr_en,           // write qualifier
    input  slot_idx_t io_addr,            // slot or control address
    input  cfg_word_t io_wr_data,
    input  logic      load_defaults,      // level from startup_seq
    input  logic      set_ctrl_default,   // one cycle pulse
    input  slot_idx_t slot_sel,           // slot asked for by the sequencer
    output cfg_word_t slot_word,          // registered readout
    output logic      ctrl_go             // control bit 0
);

    cfg_word_t slots [NUM_SLOTS];   // one word per frame in send order
    logic      wr_hit;              // qualified host write
    logic      wr_slot;             // write lands in a slot
    logic      wr_ctrl;             // write lands in control

    // ************************************************************
    // address decode
    // ************************************************************
    assign wr_hit  = io_sel & io_sync & io_wr_en;
    assign wr_slot = wr_hit && !load_defaults && (io_addr < slot_idx_t'(NUM_SLOTS));
    assign wr_ctrl = wr_hit && (io_addr == CTRL_ADDR);     // 27 to 31 fall through

    // slot storage with default reload on top
    always_ff @(posedge slow_clk)
    begin
        if (resetS || load_defaults)
        begin
            for (int k = 0; k < NUM_SLOTS; k++)
            begin
                slots[k] <= slot_default(slot_idx_t'(k));
            end
        end
        else if (wr_slot)
        begin
            slots[io_addr] <= io_wr_data;
        end
    end

    // control register
    // only bit 0 has a function so only bit 0 is kept
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            ctrl_go <= 1'b0;                    // startup alone sets it
        end
        else if (set_ctrl_default)
        begin
            ctrl_go <= CTRL_DEFAULT[0];
        end
        else if (wr_ctrl)
        begin
            ctrl_go <= io_wr_data[0];
        end
    end

    // ************************************************************
    // slot readout
    // ************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (wr_slot && (io_addr == slot_sel))
        begin
            slot_word <= io_wr_data;            // same-cycle write passes straight through
        end
        else if (slot_sel < slot_idx_t'(NUM_SLOTS))
        begin
            slot_word <= slots[slot_sel];
        end
        else
        begin
            slot_word <= '0;                    // no slot behind this number
        end
    end

endmodule

// ==== hdl/startup_seq.sv ====
module startup_seq
    import clk_synth_timing_pkg::*;
(
    input  logic slow_clk,
    input  logic resetS,
    output logic load_defaults,       // slots back to defaults
    output logic set_ctrl_default,    // arms the first pass
    output logic startup_done         // high until next reset
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_WAIT,
        ST_LOAD,
        ST_SET_CTRL,
        ST_DONE
    } state_t;

    state_t       state;
    startup_cnt_t cnt;                // wait and load timer

    // ************************************************************
    // one-shot sequence after each reset
    // ************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    cnt   <= '0;
                    state <= ST_WAIT;
                end
                ST_WAIT:
                begin
                    // idle cycle already counts toward the wait
                    if (cnt == startup_cnt_t'(STARTUP_WAIT_CYCLES - 2))
                    begin
                        cnt   <= '0;
                        state <= ST_LOAD;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_LOAD:
                begin
                    if (cnt == startup_cnt_t'(DEFAULT_LOAD_CYCLES - 1))
                    begin
                        cnt   <= '0;
                        state <= ST_SET_CTRL;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_SET_CTRL: state <= ST_DONE;      // single cycle
                ST_DONE:     state <= ST_DONE;      // parked until reset
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // outputs straight from the state register
    assign load_defaults    = (state == ST_LOAD);
    assign set_ctrl_default = (state == ST_SET_CTRL);
    assign startup_done     = (state == ST_DONE);

endmodule

// ==== hdl/prog_sequencer.sv ====
module prog_sequencer
    import clk_synth_reg_pkg::*;
    import clk_synth_timing_pkg::*;
(
    input  logic      slow_clk,
    input  logic      resetS,
    input  logic      ctrl_go,        // control bit 0
    input  logic      startup_done,   // sync only after startup
    input  logic      frame_busy,     // shifter running
    output slot_idx_t slot_sel,       // slot being sent
    output logic      frame_start,    // load and go pulse
    output logic      sync            // low-active sync to synthesizer
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_SELECT,
        ST_START,
        ST_SHIFT,
        ST_NEXT,
        ST_SYNC_LOW
    } state_t;

    state_t   state;
    logic     ctrl_go_q;              // previous ctrl_go
    logic     go_rise;
    logic     busy_seen;              // frame_busy went high this frame
    bit_cnt_t sync_cnt;

    // ************************************************************
    // control edge detect
    // ************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            ctrl_go_q <= 1'b0;
        end
        else
        begin
            ctrl_go_q <= ctrl_go;
        end
    end

    assign go_rise     = ctrl_go & ~ctrl_go_q;
    assign frame_start = (state == ST_START);

    // ************************************************************
    // pass over all slots then optional sync pulse
    // ************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= ST_IDLE;
            slot_sel  <= '0;
            busy_seen <= 1'b0;
            sync_cnt  <= '0;
            sync      <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (go_rise)                    // edges seen elsewhere are dropped
                    begin
                        slot_sel <= '0;
                        state    <= ST_SELECT;
                    end
                end
                ST_SELECT: state <= ST_START;       // slot_word settles here
                ST_START:
                begin
                    busy_seen <= 1'b0;
                    state     <= ST_SHIFT;
                end
                ST_SHIFT:
                begin
                    // wait for busy high then low
                    if (frame_busy)
                    begin
                        busy_seen <= 1'b1;
                    end
                    else if (busy_seen)
                    begin
                        state <= ST_NEXT;
                    end
                end
                ST_NEXT:
                begin
                    if (slot_sel == slot_idx_t'(NUM_SLOTS - 1))
                    begin
                        if (startup_done)
                        begin
                            sync     <= 1'b0;
                            sync_cnt <= '0;
                            state    <= ST_SYNC_LOW;
                        end
                        else
                        begin
                            state <= ST_IDLE;       // early pass without sync
                        end
                    end
                    else
                    begin
                        slot_sel <= slot_sel + 1'b1;
                        state    <= ST_SELECT;
                    end
                end
                ST_SYNC_LOW:
                begin
                    if (sync_cnt == bit_cnt_t'(SYNC_LOW_CYCLES - 1))
                    begin
                        sync  <= 1'b1;
                        state <= ST_IDLE;
                    end
                    else
                    begin
                        sync_cnt <= sync_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/frame_shifter.sv ====
module frame_shifter
    import clk_synth_reg_pkg::*;
    import clk_synth_timing_pkg::*;
(
    input  logic      slow_clk,
    input  logic      resetS,
    input  logic      frame_start,    // load slot_word and go
    input  cfg_word_t slot_word,
    output logic      ddat,           // serial data MSB first
    output logic      dlen,           // low-active latch enable
    output logic      frame_busy
);

    cfg_word_t sreg;                  // outgoing word
    bit_cnt_t  bit_cnt;               // bits already on the line

    // ************************************************************
    // 32 bit MSB-first shifter
    // ************************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            sreg    <= '0;                  // keeps ddat low
            bit_cnt <= '0;
            dlen    <= 1'b1;
        end
        else if (frame_start && dlen)
        begin
            sreg    <= slot_word;
            bit_cnt <= '0;
            dlen    <= 1'b0;                // frame opens next cycle
        end
        else if (!dlen)
        begin
            sreg <= {sreg[WORD_BITS-2:0], 1'b0};    // zeros fill behind
            if (bit_cnt == bit_cnt_t'(WORD_BITS - 1))
            begin
                dlen <= 1'b1;               // last bit done and latched
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign ddat       = sreg[WORD_BITS-1];
    assign frame_busy = ~dlen;          // busy for the whole low window

endmodule

// ==== hdl/clk_synth_intf.sv ====
module clk_synth_intf
    import clk_synth_reg_pkg::*;
(
    input  logic      slow_clk,
    input  logic      resetS,
    input  logic      io_sel,
    input  logic      io_sync,
    input  logic      io_wr_en,
    input  slot_idx_t io_addr,
    input  cfg_word_t io_wr_data,
    output logic      dclk,           // synthesizer serial clock
    output logic      ddat,
    output logic      dlen,
    output logic      sync
);

    logic      load_defaults;
    logic      set_ctrl_default;
    logic      startup_done;
    logic      ctrl_go;
    slot_idx_t slot_sel;
    cfg_word_t slot_word;
    logic      frame_start;
    logic      frame_busy;

    // synthesizer latches on the falling edge of slow_clk
    assign dclk = ~slow_clk;

    // ************************************************************
    // block instances
    // ************************************************************
    cfg_reg_bank cfg_reg_bank_i (
        .slow_clk         (slow_clk),
        .resetS           (resetS),
        .io_sel           (io_sel),
        .io_sync          (io_sync),
        .io_wr_en         (io_wr_en),
        .io_addr          (io_addr),
        .io_wr_data       (io_wr_data),
        .load_defaults    (load_defaults),
        .set_ctrl_default (set_ctrl_default),
        .slot_sel         (slot_sel),
        .slot_word        (slot_word),
        .ctrl_go          (ctrl_go)
    );

    startup_seq startup_seq_i (
        .slow_clk         (slow_clk),
        .resetS           (resetS),
        .load_defaults    (load_defaults),
        .set_ctrl_default (set_ctrl_default),
        .startup_done     (startup_done)
    );

    prog_sequencer prog_sequencer_i (
        .slow_clk     (slow_clk),
        .resetS       (resetS),
        .ctrl_go      (ctrl_go),
        .startup_done (startup_done),
        .frame_busy   (frame_busy),
        .slot_sel     (slot_sel),
        .frame_start  (frame_start),
        .sync         (sync)
    );

    frame_shifter frame_shifter_i (
        .slow_clk    (slow_clk),
        .resetS      (resetS),
        .frame_start (frame_start),
        .slot_word   (slot_word),
        .ddat        (ddat),
        .dlen        (dlen),
        .frame_busy  (frame_busy)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen
(
    output logic slow_clk,
    output logic resetS,
    input  logic reset_req          // sampled on the rising edge
);

    // free running clock with period 10
    initial
    begin
        slow_clk = 1'b0;
        forever #5 slow_clk = ~slow_clk;
    end

    // power-on reset then reset again on request
    initial
    begin
        resetS = 1'b1;
        repeat (5) @(negedge slow_clk);     // five rising edges in reset
        resetS = 1'b0;
        forever
        begin
            @(posedge slow_clk);
            if (reset_req)
            begin
                @(negedge slow_clk);
                resetS = 1'b1;
                repeat (5) @(negedge slow_clk);
                resetS = 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_clk_synth_intf.sv ====
module tb_clk_synth_intf
    import clk_synth_reg_pkg::*;
    import clk_synth_timing_pkg::*;
();

    localparam int IDLE_CHECK_CYCLES = 1000;    // quiet window after reset
    localparam int FRAME_GAP_LIMIT   = 40;      // between frames of one pass

    logic      slow_clk;
    logic      resetS;
    logic      reset_req;
    logic      io_sel;
    logic      io_sync;
    logic      io_wr_en;
    slot_idx_t io_addr;
    cfg_word_t io_wr_data;
    logic      dclk;
    logic      ddat;
    logic      dlen;
    logic      sync;

    cfg_word_t   expected [NUM_SLOTS];      // model of the slot contents
    logic [31:0] lfsr_state = 32'hfeb7ad8e;
    int          word_errors  = 0;
    int          level_errors = 0;
    int          count_errors = 0;
    int          timeouts     = 0;
    logic        timed_out    = 1'b0;       // stops the remaining tests

    tb_clk_gen clk_gen_i (
        .slow_clk  (slow_clk),
        .resetS    (resetS),
        .reset_req (reset_req)
    );

    clk_synth_intf clk_synth_intf_i (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .io_sel     (io_sel),
        .io_sync    (io_sync),
        .io_wr_en   (io_wr_en),
        .io_addr    (io_addr),
        .io_wr_data (io_wr_data),
        .dclk       (dclk),
        .ddat       (ddat),
        .dlen       (dlen),
        .sync       (sync)
    );

    // ************************************************************
    // random data and compare tasks
    // ************************************************************
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic next_random_word(output cfg_word_t w);
        w = '0;
        for (int b = 0; b < WORD_BITS; b++)
        begin
            w = {w[WORD_BITS-2:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_word(input string what, input cfg_word_t got, input cfg_word_t exp);
        if (got !== exp)
        begin
            word_errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            level_errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            count_errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timeouts++;
        timed_out = 1'b1;
    endtask

    // ************************************************************
    // host driver and frame receiver
    // ************************************************************
    task automatic drive_write(input slot_idx_t addr, input cfg_word_t data,
                               input logic sel, input logic syn, input logic wen);
        @(negedge slow_clk);
        io_sel     = sel;
        io_sync    = syn;
        io_wr_en   = wen;
        io_addr    = addr;
        io_wr_data = data;
        if (sel && syn && wen && (int'(addr) < NUM_SLOTS))
        begin
            expected[addr] = data;              // only qualified slot writes land
        end
        @(negedge slow_clk);
        io_sel   = 1'b0;
        io_sync  = 1'b0;
        io_wr_en = 1'b0;
    endtask

    // control bit 0 low then high gives the rising edge
    task automatic start_pass();
        drive_write(CTRL_ADDR, 32'h0000_0000, 1'b1, 1'b1, 1'b1);
        drive_write(CTRL_ADDR, 32'h0000_0001, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic load_default_model();
        for (int k = 0; k < NUM_SLOTS; k++)
        begin
            expected[k] = SLOT_DEFAULTS[k];
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge slow_clk);                    // reset moves on falling edges
        while (resetS && cycles < 20)
        begin
            @(posedge slow_clk);
            cycles++;
        end
        if (resetS)
        begin
            report_timeout("resetS never went low");
            return;
        end
        @(negedge slow_clk);
    endtask

    // ddat sampled on the falling edge like the synthesizer
    task automatic receive_frame(input int limit, output cfg_word_t word, output int waited);
        int bits;
        word   = '0;
        waited = 0;
        bits   = 0;
        if (timed_out)
        begin
            return;
        end
        while (dlen && waited < limit)
        begin
            @(negedge slow_clk);
            waited++;
        end
        if (dlen)
        begin
            report_timeout($sformatf("dlen did not fall within %0d cycles", limit));
            return;
        end
        while (!dlen && bits < 40)              // 40 bounds a stuck dlen
        begin
            word = {word[WORD_BITS-2:0], ddat};
            bits++;
            @(negedge slow_clk);
        end
        check_count("frame length in bits", bits, WORD_BITS);
    endtask

    task automatic check_sync_pulse();
        int lead;
        int low_cycles;
        lead       = 0;
        low_cycles = 0;
        while (sync && lead < 4)
        begin
            @(negedge slow_clk);
            lead++;
        end
        if (sync)
        begin
            report_timeout("sync never went low after the last frame");
            return;
        end
        check_level("sync low within 2 cycles", lead <= 2, 1'b1);
        while (!sync && low_cycles < 64)
        begin
            @(negedge slow_clk);
            low_cycles++;
        end
        check_count("sync low cycles", low_cycles, SYNC_LOW_CYCLES);
    endtask

    // dclk runs opposite to slow_clk, sampled away from the edges
    task automatic check_dclk();
        for (int c = 0; c < 4; c++)
        begin
            @(posedge slow_clk);
            #2;
            check_level("dclk with slow_clk high", dclk, 1'b0);
            @(negedge slow_clk);
            #2;
            check_level("dclk with slow_clk low", dclk, 1'b1);
        end
        @(negedge slow_clk);                    // back on the drive edge
    endtask

    // all slots in order, sync pulse, then silence
    task automatic check_pass(input string label, input int first_limit, output int first_wait);
        cfg_word_t got;
        int        waited;
        logic      quiet;
        first_wait = 0;
        quiet      = 1'b1;
        for (int k = 0; k < NUM_SLOTS; k++)
        begin
            receive_frame((k == 0) ? first_limit : FRAME_GAP_LIMIT, got, waited);
            if (timed_out)
            begin
                return;
            end
            if (k == 0)
            begin
                first_wait = waited;
            end
            check_word($sformatf("%s slot %0d", label, k), got, expected[k]);
        end
        check_sync_pulse();
        for (int c = 0; c < 64; c++)            // no 27th frame
        begin
            quiet &= dlen;
            @(negedge slow_clk);
        end
        check_level({label, " dlen quiet after pass"}, quiet, 1'b1);
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic test_idle_after_reset();
        logic dlen_high;
        logic sync_high;
        dlen_high = 1'b1;
        sync_high = 1'b1;
        for (int c = 0; c < IDLE_CHECK_CYCLES; c++)
        begin
            dlen_high &= dlen;
            sync_high &= sync;
            @(negedge slow_clk);
        end
        check_level("dlen idle after reset", dlen_high, 1'b1);
        check_level("sync idle after reset", sync_high, 1'b1);
        check_dclk();
    endtask

    task automatic test_startup_pass();
        int first_wait;
        load_default_model();
        check_pass("startup", 40000, first_wait);
        check_level("startup pass after wait",
                    (first_wait + IDLE_CHECK_CYCLES) >= STARTUP_WAIT_CYCLES, 1'b1);
    endtask

    task automatic test_host_program();
        cfg_word_t data;
        int        first_wait;
        for (int k = 0; k < NUM_SLOTS; k++)
        begin
            next_random_word(data);
            drive_write(slot_idx_t'(k), data, 1'b1, 1'b1, 1'b1);
        end
        start_pass();
        check_pass("host", FRAME_GAP_LIMIT, first_wait);
    endtask

    task automatic test_qualified_writes();
        cfg_word_t data;
        int        first_wait;
        next_random_word(data);
        drive_write(5'd3, data, 1'b0, 1'b1, 1'b1);     // io_sel low
        next_random_word(data);
        drive_write(5'd10, data, 1'b1, 1'b0, 1'b1);    // io_sync low
        next_random_word(data);
        drive_write(5'd17, data, 1'b1, 1'b1, 1'b0);    // io_wr_en low
        next_random_word(data);
        drive_write(5'd30, data, 1'b1, 1'b1, 1'b1);    // unmapped address
        start_pass();
        check_pass("unqualified", FRAME_GAP_LIMIT, first_wait);
    endtask

    task automatic test_reset_defaults();
        int first_wait;
        @(negedge slow_clk);
        reset_req = 1'b1;
        @(negedge slow_clk);
        reset_req = 1'b0;
        wait_reset_release();
        load_default_model();                   // written data is gone
        check_pass("after reset", 40000, first_wait);
        check_level("no pass before startup wait", first_wait >= STARTUP_WAIT_CYCLES, 1'b1);
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************
    initial
    begin
        int total;
        reset_req  = 1'b0;
        io_sel     = 1'b0;
        io_sync    = 1'b0;
        io_wr_en   = 1'b0;
        io_addr    = '0;
        io_wr_data = '0;
        wait_reset_release();
        if (!timed_out)
        begin
            test_idle_after_reset();
        end
        if (!timed_out)
        begin
            test_startup_pass();
        end
        if (!timed_out)
        begin
            test_host_program();
        end
        if (!timed_out)
        begin
            test_qualified_writes();
        end
        if (!timed_out)
        begin
            test_reset_defaults();
        end
        total = word_errors + level_errors + count_errors + timeouts;
        $display("summary: %0d word errors, %0d level errors, %0d count errors, %0d timeouts",
                 word_errors, level_errors, count_errors, timeouts);
        if (total == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hdl/clk_synth_reg_pkg.sv
hdl/clk_synth_timing_pkg.sv
hdl/cfg_reg_bank.sv
hdl/startup_seq.sv
hdl/prog_sequencer.sv
hdl/frame_shifter.sv
hdl/clk_synth_intf.sv
tests/tb_clk_gen.sv
tests/tb_clk_synth_intf.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_clk_synth_intf -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
